// File: filelist.f
+incdir+tests
logic/hdmi_pkg.sv
logic/video_timing.sv
logic/video_display.sv
logic/tmds_encoder.sv
logic/hdmi_top.sv
tests/tb_hdmi_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the HDMI output stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_hdmi_top -f filelist.f \
    --Mdir obj_dir -o sim_tb_hdmi_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb_hdmi_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    echo "simulation passed"
    exit 0
fi

echo "pass message not found"
exit 1

// File: tests/tb_ref_model.svh
/* Testbench reference model */

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// --------------------------------------------------
// frame buffer content
// --------------------------------------------------
// hash of position and frame salt
// every bit of x and y reaches the colour
function automatic rgb565_t fb_pixel(input logic [POS_W-1:0] x, input logic [POS_W-1:0] y,
                                     input logic [31:0] s);
    logic [31:0] h;
    h = s ^ (32'(x) * 32'h9e37_79b9) ^ (32'(y) * 32'h85eb_ca6b);
    h = h ^ (h >> 15);  // fold high bits down
    return rgb565_t'(h[15:0] ^ h[31:16]);
endfunction

// 565 to 888 with zero low bits
function automatic rgb888_t expand565(input rgb565_t p);
    rgb888_t e;
    e.r = 8'(p.r) << 3;
    e.g = 8'(p.g) << 2;
    e.b = 8'(p.b) << 3;
    return e;
endfunction

// --------------------------------------------------
// DVI 8b/10b with disparity carried by the caller
// --------------------------------------------------
function automatic logic [9:0] tmds_ref_encode(input logic [7:0] d, input logic [1:0] ctl,
                                               input logic de, ref int disp);
    logic [8:0] qm;
    logic [9:0] q;
    logic       xn;    // xnor chain
    int         n1_d;
    int         n1_q;
    int         n0_q;
    if (!de) begin
        disp = 0;  // blanking clears the balance
        case (ctl)
            2'b00:   q = CTRL_TOKEN_00;
            2'b01:   q = CTRL_TOKEN_01;
            2'b10:   q = CTRL_TOKEN_10;
            default: q = CTRL_TOKEN_11;
        endcase
    end else begin
        n1_d = $countones(d);
        xn = (n1_d > 4) || ((n1_d == 4) && !d[0]);
        qm[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            qm[i] = xn ? (qm[i-1] ~^ d[i]) : (qm[i-1] ^ d[i]);
        end
        qm[8] = !xn;
        n1_q = $countones(qm[7:0]);
        n0_q = 8 - n1_q;
        if ((disp == 0) || (n1_q == n0_q)) begin
            q[9]   = ~qm[8];
            q[8]   = qm[8];
            q[7:0] = qm[8] ? qm[7:0] : ~qm[7:0];
            disp   = qm[8] ? (disp + n1_q - n0_q) : (disp + n0_q - n1_q);
        end else if (((disp > 0) && (n1_q > n0_q)) || ((disp < 0) && (n0_q > n1_q))) begin
            q    = {1'b1, qm[8], ~qm[7:0]};  // invert to pull back toward zero
            disp = disp + 2 * int'(qm[8]) + n0_q - n1_q;
        end else begin
            q    = {1'b0, qm[8], qm[7:0]};
            disp = disp - 2 * int'(!qm[8]) + n1_q - n0_q;
        end
    end
    return q;
endfunction

// compare and stop at the first mismatch
task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("ERROR at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
        $display("*** FAILED ***");
        $fatal(1, "%s mismatch", what);
    end
endtask

`endif

// File: tests/tb_hdmi_top.sv
/* HDMI output stage testbench */

`timescale 1ns/1ps

module tb_hdmi_top import hdmi_pkg::*; ();

    logic             hdmi_clk;
    logic             rst_n;
    rgb565_t          rd_data;
    logic             rd_en;
    logic             video_vs;
    logic [POS_W-1:0] pixel_xpos;
    logic [POS_W-1:0] pixel_ypos;
    logic [9:0]       tmds_ch0;
    logic [9:0]       tmds_ch1;
    logic [9:0]       tmds_ch2;

    integer      seed;         // $random state
    logic [31:0] salt;         // changes every frame

    `include "tb_ref_model.svh"

    // scan model state for the cycle last checked
    pos_t       m_cnt;       // x is the h counter and y the v counter
    sync_t      m_sync;
    logic       m_req;       // expected rd_en
    rgb565_t    m_req_pix;   // colour the frame buffer returns for it
    rgb565_t    m_pix;       // colour in front of the encoders
    logic [9:0] e_sym [3];   // expected symbols for ch0 to ch2
    int         disp0;
    int         disp1;
    int         disp2;
    int         vs_hi;       // per-frame counts
    int         rd_cnt;
    int         period;
    int         vs_edges;    // vsync rising edges since reset
    logic       vs_prev;

    hdmi_top i_hdmi_top (
        .hdmi_clk   (hdmi_clk),
        .rst_n      (rst_n),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .video_vs   (video_vs),
        .pixel_xpos (pixel_xpos),
        .pixel_ypos (pixel_ypos),
        .tmds_ch0   (tmds_ch0),
        .tmds_ch1   (tmds_ch1),
        .tmds_ch2   (tmds_ch2)
    );

    initial begin
        hdmi_clk = 1'b0;
        forever #2 hdmi_clk = ~hdmi_clk;  // 4 ns period
    end

    // one counter step with line and frame wrap
    function automatic pos_t scan_next(input pos_t c);
        pos_t n;
        n = c;
        if (c.x == H_TOTAL - POS_W'(1)) begin
            n.x = '0;
            n.y = (c.y == V_TOTAL - POS_W'(1)) ? '0 : c.y + POS_W'(1);
        end else begin
            n.x = c.x + POS_W'(1);
        end
        return n;
    endfunction

    function automatic logic in_active(input pos_t c);
        return (c.x >= H_SYNC + H_BACK) && (c.x < H_SYNC + H_BACK + H_DISP) &&
               (c.y >= V_SYNC + V_BACK) && (c.y < V_SYNC + V_BACK + V_DISP);
    endfunction

    task automatic wait_frame_start();
        int   n;
        int   limit;
        logic seen;
        logic vs_last;
        n = 0;
        limit = 4 * int'(H_TOTAL) * int'(V_TOTAL);
        seen = 1'b0;
        vs_last = video_vs;
        while (!seen && (n < limit)) begin
            @(negedge hdmi_clk);
            seen = video_vs && !vs_last;  // vsync rising edge
            vs_last = video_vs;
            n++;
        end
        if (!seen) begin
            $display("timed out waiting for frame");
            $display("*** FAILED ***");
            $fatal(1, "no vsync edge");
        end
    endtask

    // --------------------------------------------------
    // frame buffer model with latency 1
    // --------------------------------------------------
    initial begin : frame_buffer
        logic             req_q;
        logic [POS_W-1:0] req_x;
        logic [POS_W-1:0] req_y;
        logic             vs_last;
        seed = 32'hf322_4d70;
        salt = $random(seed);
        rd_data = '0;
        req_q = 1'b0;
        req_x = '0;
        req_y = '0;
        vs_last = 1'b0;
        forever begin
            @(negedge hdmi_clk);
            // answer last cycle's request
            rd_data = req_q ? fb_pixel(req_x, req_y, salt) : rgb565_t'(16'h0bad);
            if (video_vs && !vs_last) begin
                salt = $random(seed);  // new picture each frame
            end
            vs_last = video_vs;
            req_q = rd_en;
            req_x = pixel_xpos;
            req_y = pixel_ypos;
        end
    end

    // --------------------------------------------------
    // per-cycle compare
    // --------------------------------------------------
    initial begin : compare
        pos_t    nxt;
        logic    fetch_e;
        rgb888_t rgb;
        @(posedge hdmi_clk);
        forever begin
            @(negedge hdmi_clk);
            if (!rst_n) begin
                check(32'(rd_en), 32'd0, "rd_en in reset");
                check(32'(video_vs), 32'd0, "video_vs in reset");
                check(32'(tmds_ch0), 32'(CTRL_TOKEN_00), "tmds_ch0 in reset");
                check(32'(tmds_ch1), 32'(CTRL_TOKEN_00), "tmds_ch1 in reset");
                check(32'(tmds_ch2), 32'(CTRL_TOKEN_00), "tmds_ch2 in reset");
                m_cnt = '0;
                m_sync = '0;
                m_req = 1'b0;
                m_req_pix = '0;
                m_pix = BORDER_RGB565;
                e_sym[0] = CTRL_TOKEN_00;
                e_sym[1] = CTRL_TOKEN_00;
                e_sym[2] = CTRL_TOKEN_00;
                disp0 = 0;
                disp1 = 0;
                disp2 = 0;
                vs_prev = 1'b0;
                vs_edges = 0;
            end else begin
                // symbols come from last cycle's pixel and sync
                rgb = expand565(m_pix);
                e_sym[0] = tmds_ref_encode(rgb.b, {m_sync.vs, m_sync.hs}, m_sync.de, disp0);
                e_sym[1] = tmds_ref_encode(rgb.g, 2'b00, m_sync.de, disp1);
                e_sym[2] = tmds_ref_encode(rgb.r, 2'b00, m_sync.de, disp2);
                m_pix = m_req ? m_req_pix : BORDER_RGB565;
                m_cnt = scan_next(m_cnt);
                m_sync.hs = m_cnt.x < H_SYNC;
                m_sync.vs = m_cnt.y < V_SYNC;
                m_sync.de = in_active(m_cnt);
                // request for the pixel shown next cycle
                nxt = scan_next(m_cnt);
                fetch_e = in_active(nxt);
                nxt.x = nxt.x - (H_SYNC + H_BACK);
                nxt.y = nxt.y - (V_SYNC + V_BACK);
                m_req = fetch_e && (nxt.x < CAM_H) && (nxt.y < CAM_V);
                if (m_req) begin
                    m_req_pix = fb_pixel(nxt.x, nxt.y, salt);
                end
                check(32'(rd_en), 32'(m_req), "rd_en");
                check(32'(video_vs), 32'(m_sync.vs), "video_vs");
                if (fetch_e) begin
                    check(32'(pixel_xpos), 32'(nxt.x), "pixel_xpos");
                    check(32'(pixel_ypos), 32'(nxt.y), "pixel_ypos");
                end
                if (rd_en) begin
                    check(32'(pixel_xpos < CAM_H), 32'd1, "read x outside window");
                    check(32'(pixel_ypos < CAM_V), 32'd1, "read y outside window");
                end
                check(32'(tmds_ch0), 32'(e_sym[0]), "tmds_ch0");
                check(32'(tmds_ch1), 32'(e_sym[1]), "tmds_ch1");
                check(32'(tmds_ch2), 32'(e_sym[2]), "tmds_ch2");
                // frame counts close at each vsync rising edge
                if (video_vs && !vs_prev) begin
                    // the edge right after reset comes one cycle late
                    // so full frames start at the second edge
                    if (vs_edges >= 2) begin
                        check(32'(vs_hi), 32'(V_SYNC) * 32'(H_TOTAL), "vsync cycles per frame");
                        check(32'(rd_cnt), 32'(CAM_H) * 32'(CAM_V), "reads per frame");
                        check(32'(period), 32'(H_TOTAL) * 32'(V_TOTAL), "frame length");
                    end
                    vs_edges++;
                    vs_hi = 1;
                    rd_cnt = int'(rd_en);
                    period = 1;
                end else begin
                    vs_hi = vs_hi + int'(video_vs);
                    rd_cnt = rd_cnt + int'(rd_en);
                    period++;
                end
                vs_prev = video_vs;
            end
        end
    end

    // --------------------------------------------------
    // reset and frame loop
    // --------------------------------------------------
    initial begin : main
        rst_n <= 1'b0;
        repeat (5) @(negedge hdmi_clk);
        rst_n <= 1'b1;
        // first edge after reset is a short frame
        // three full frames lie between the second and fifth edge
        for (int f = 0; f < 5; f++) begin
            wait_frame_start();
        end
        repeat (4) @(negedge hdmi_clk);  // last frame counts settle
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: logic/hdmi_top.sv
/* HDMI output stage top */

`timescale 1ns/1ps

module hdmi_top import hdmi_pkg::*; (
    input  logic             hdmi_clk,
    input  logic             rst_n,
    input  rgb565_t          rd_data,     // frame buffer data, latency 1
    output logic             rd_en,       // frame buffer read strobe
    output logic             video_vs,    // vsync, one cycle ahead of symbols
    output logic [POS_W-1:0] pixel_xpos,  // valid with fetch
    output logic [POS_W-1:0] pixel_ypos,
    output logic [9:0]       tmds_ch0,    // blue + hs/vs
    output logic [9:0]       tmds_ch1,    // green
    output logic [9:0]       tmds_ch2     // red
);

    sync_t   sync;     // hs/vs/de aligned with pixel
    logic    fetch;
    pos_t    pos;
    rgb565_t pixel;    // selected colour
    rgb888_t rgb;      // widened colour

    assign video_vs   = sync.vs;
    assign pixel_xpos = pos.x;
    assign pixel_ypos = pos.y;

    // 565 -> 888, low bits zero
    assign rgb.r = {pixel.r, 3'b000};
    assign rgb.g = {pixel.g, 2'b00};
    assign rgb.b = {pixel.b, 3'b000};

    // --------------------------------------------------
    // timing and pixel source
    // --------------------------------------------------
    video_timing u_video_timing (
        .hdmi_clk (hdmi_clk),
        .rst_n    (rst_n),
        .sync     (sync),
        .fetch    (fetch),
        .pos      (pos)
    );

    video_display u_video_display (
        .hdmi_clk (hdmi_clk),
        .rst_n    (rst_n),
        .fetch    (fetch),
        .pos      (pos),
        .rd_en    (rd_en),
        .rd_data  (rd_data),
        .pixel    (pixel)
    );

    // --------------------------------------------------
    // TMDS channels
    // --------------------------------------------------
    tmds_encoder u_tmds_ch0 (
        .hdmi_clk (hdmi_clk),
        .rst_n    (rst_n),
        .de       (sync.de),
        .c0       (sync.hs),  // sync rides on blue
        .c1       (sync.vs),
        .din      (rgb.b),
        .dout     (tmds_ch0)
    );

    tmds_encoder u_tmds_ch1 (
        .hdmi_clk (hdmi_clk),
        .rst_n    (rst_n),
        .de       (sync.de),
        .c0       (1'b0),
        .c1       (1'b0),
        .din      (rgb.g),
        .dout     (tmds_ch1)
    );

    tmds_encoder u_tmds_ch2 (
        .hdmi_clk (hdmi_clk),
        .rst_n    (rst_n),
        .de       (sync.de),
        .c0       (1'b0),
        .c1       (1'b0),
        .din      (rgb.r),
        .dout     (tmds_ch2)
    );

endmodule

// File: logic/tmds_encoder.sv
/* DVI TMDS channel encoder */

`timescale 1ns/1ps

module tmds_encoder import hdmi_pkg::*; (
    input  logic       hdmi_clk,
    input  logic       rst_n,
    input  logic       de,    // data period
    input  logic       c0,    // control bit 0
    input  logic       c1,    // control bit 1
    input  logic [7:0] din,   // video byte
    output logic [9:0] dout   // 10-bit symbol, one cycle later
);

    // number of ones in a byte
    function automatic logic [3:0] ones8(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, v[i]};
        end
        return n;
    endfunction

    logic [3:0]        n1_d;      // ones in din
    logic              use_xnor;  // chaining choice
    logic [8:0]        q_m;       // transition minimised word
    logic [3:0]        n1_q;      // ones in q_m[7:0]
    logic signed [5:0] bal;       // ones minus zeros of q_m[7:0]
    logic signed [5:0] cnt;       // running disparity
    logic signed [5:0] cnt_nxt;
    logic [9:0]        sym;       // data symbol
    logic [9:0]        ctrl_tok;  // control symbol

    // --------------------------------------------------
    // stage one, transition minimising
    // --------------------------------------------------
    always_comb begin
        n1_d     = ones8(din);
        // xnor when the byte is mostly ones
        use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !din[0]);
        q_m[0]   = din[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ din[i]) : (q_m[i-1] ^ din[i]);
        end
        q_m[8]   = ~use_xnor;  // 1 means xor chain
    end

    // --------------------------------------------------
    // stage two, DC balance
    // --------------------------------------------------
    always_comb begin
        n1_q = ones8(q_m[7:0]);
        bal  = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;  // 2*n1 - 8
        if ((cnt == 6'sd0) || (bal == 6'sd0)) begin
            // no bias either way, bit 9 marks inversion
            sym     = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            cnt_nxt = q_m[8] ? (cnt + bal) : (cnt - bal);
        end else if (((cnt > 6'sd0) && (bal > 6'sd0)) ||
                     ((cnt < 6'sd0) && (bal < 6'sd0))) begin
            sym     = {1'b1, q_m[8], ~q_m[7:0]};  // invert to pull back
            cnt_nxt = cnt - bal + (q_m[8] ? 6'sd2 : 6'sd0);
        end else begin
            sym     = {1'b0, q_m[8], q_m[7:0]};  // already heading back
            cnt_nxt = cnt + bal - (q_m[8] ? 6'sd0 : 6'sd2);
        end
    end

    // --------------------------------------------------
    // control period
    // --------------------------------------------------
    always_comb begin
        case ({c1, c0})
            2'b00:   ctrl_tok = CTRL_TOKEN_00;
            2'b01:   ctrl_tok = CTRL_TOKEN_01;
            2'b10:   ctrl_tok = CTRL_TOKEN_10;
            default: ctrl_tok = CTRL_TOKEN_11;
        endcase
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    always_ff @(posedge hdmi_clk) begin
        if (!rst_n) begin
            dout <= CTRL_TOKEN_00;
            cnt  <= '0;
        end else if (de) begin
            dout <= sym;
            cnt  <= cnt_nxt;
        end else begin
            dout <= ctrl_tok;
            cnt  <= '0;  // disparity restarts every blanking
        end
    end

endmodule

// File: logic/video_display.sv
/* Camera window and border fill */

`timescale 1ns/1ps

module video_display import hdmi_pkg::*; (
    input  logic    hdmi_clk,
    input  logic    rst_n,
    input  logic    fetch,    // next cycle is active video
    input  pos_t    pos,      // pixel to be shown next cycle
    output logic    rd_en,    // frame buffer read strobe
    input  rgb565_t rd_data,  // one cycle after rd_en
    output rgb565_t pixel     // colour for the current de cycle
);

    logic in_win;  // pos inside camera window
    logic hit;     // request issued this cycle
    logic hit_q;   // request issued last cycle

    // --------------------------------------------------
    // window test and read request
    // --------------------------------------------------
    // window anchored at (0,0), so two upper bounds suffice
    assign in_win = (pos.x < CAM_H) && (pos.y < CAM_V);

    assign hit   = fetch && in_win;
    assign rd_en = hit;  // same cycle as fetch

    // --------------------------------------------------
    // align with read data
    // --------------------------------------------------
    // frame buffer has fixed latency 1, no stall
    always_ff @(posedge hdmi_clk) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit;
        end
    end

    // --------------------------------------------------
    // output mux
    // --------------------------------------------------
    // camera data inside window, fill colour elsewhere
    // blanking cycles show border too, encoder ignores it
    always_comb begin
        if (hit_q) begin
            pixel = rd_data;
        end else begin
            pixel = BORDER_RGB565;
        end
    end

endmodule

// File: logic/video_timing.sv
/* Video timing generator */

`timescale 1ns/1ps

module video_timing import hdmi_pkg::*; (
    input  logic  hdmi_clk,
    input  logic  rst_n,
    output sync_t sync,   // registered, follows counters
    output logic  fetch,  // next cycle is an active pixel
    output pos_t  pos     // position of that pixel
);

    logic [POS_W-1:0] h_cnt;   // pixel within line
    logic [POS_W-1:0] v_cnt;   // line within frame
    logic [POS_W-1:0] h_nxt;   // counter values one cycle ahead
    logic [POS_W-1:0] v_nxt;
    logic             h_wrap;  // last pixel of the line
    logic             h_act;
    logic             v_act;

    // --------------------------------------------------
    // counters
    // --------------------------------------------------
    assign h_wrap = (h_cnt == H_TOTAL - POS_W'(1));

    always_comb begin
        h_nxt = h_wrap ? '0 : h_cnt + POS_W'(1);
        v_nxt = v_cnt;
        if (h_wrap) begin
            // line done, step the row
            v_nxt = (v_cnt == V_TOTAL - POS_W'(1)) ? '0 : v_cnt + POS_W'(1);
        end
    end

    always_ff @(posedge hdmi_clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
        end
    end

    // --------------------------------------------------
    // decode, one cycle early
    // --------------------------------------------------
    // active window of the next counter position
    assign h_act = (h_nxt >= H_SYNC + H_BACK) && (h_nxt < H_SYNC + H_BACK + H_DISP);
    assign v_act = (v_nxt >= V_SYNC + V_BACK) && (v_nxt < V_SYNC + V_BACK + V_DISP);

    assign fetch = h_act && v_act;

    // strip sync and back porch off the counters
    // only meaningful while fetch is high
    assign pos.x = h_nxt - (H_SYNC + H_BACK);
    assign pos.y = v_nxt - (V_SYNC + V_BACK);

    // --------------------------------------------------
    // sync outputs
    // --------------------------------------------------
    // registered from the early decode, so de lines up
    // with the pixel returned by the frame buffer
    always_ff @(posedge hdmi_clk) begin
        if (!rst_n) begin
            sync <= '0;
        end else begin
            sync.hs <= (h_nxt < H_SYNC);  // start of line
            sync.vs <= (v_nxt < V_SYNC);  // start of frame
            sync.de <= fetch;
        end
    end

endmodule

// File: logic/hdmi_pkg.sv
/* HDMI output stage, shared definitions */

package hdmi_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int POS_W = 11;  // x/y counter width

    // horizontal timing, in pixel clocks
    localparam logic [POS_W-1:0] H_SYNC  = POS_W'(2);
    localparam logic [POS_W-1:0] H_BACK  = POS_W'(3);
    localparam logic [POS_W-1:0] H_DISP  = POS_W'(16);  // active pixels per line
    localparam logic [POS_W-1:0] H_FRONT = POS_W'(2);
    localparam logic [POS_W-1:0] H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT;

    // vertical timing, in lines
    localparam logic [POS_W-1:0] V_SYNC  = POS_W'(1);
    localparam logic [POS_W-1:0] V_BACK  = POS_W'(2);
    localparam logic [POS_W-1:0] V_DISP  = POS_W'(8);   // active lines per frame
    localparam logic [POS_W-1:0] V_FRONT = POS_W'(1);
    localparam logic [POS_W-1:0] V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT;

    // camera window, top-left anchored
    localparam logic [POS_W-1:0] CAM_H = POS_W'(12);
    localparam logic [POS_W-1:0] CAM_V = POS_W'(6);

    // --------------------------------------------------
    // DVI control tokens, indexed by {c1,c0}
    // --------------------------------------------------
    localparam logic [9:0] CTRL_TOKEN_00 = 10'b1101010100;
    localparam logic [9:0] CTRL_TOKEN_01 = 10'b0010101011;
    localparam logic [9:0] CTRL_TOKEN_10 = 10'b0101010100;
    localparam logic [9:0] CTRL_TOKEN_11 = 10'b1010101011;

    // --------------------------------------------------
    // bundled types
    // --------------------------------------------------
    typedef struct packed {
        logic hs;  // hsync, active high
        logic vs;  // vsync, active high
        logic de;  // display enable
    } sync_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef struct packed {
        logic [POS_W-1:0] x;  // column inside active area
        logic [POS_W-1:0] y;  // row inside active area
    } pos_t;

    // fill colour outside the camera window
    localparam rgb565_t BORDER_RGB565 = '{r: 5'h00, g: 6'h10, b: 5'h1f};

endpackage
